// File: pipe_defs.svh
/*
 * Width and latency macros for the five-stage pipeline.
 * Include this wherever a data width, register index or memory timing is needed.
 */

`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

`define PIPE_XLEN      32   // data and address width
`define PIPE_RA_W      5    // register index width

// data memory
`define PIPE_DM_WORDS  256  // depth in 32-bit words
`define PIPE_DM_WAIT   3    // cycles from req rising to ack rising

`endif

// File: pipe_pkg.sv
/*
 * Shared types of the pipeline.
 * Decoded operations, bypass selects and the load/store handshake states.
 */

`default_nettype none

package pipe_pkg;

    // decoded operation, carried down the pipe
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDI,
        OP_LW,
        OP_SW
    } op_e;

    // execute operand source
    typedef enum logic [1:0] {
        BP_NONE,    // register file value
        BP_MEM,
        BP_WB
    } bp_sel_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_RELEASE // waiting for ack to drop
    } lsu_state_e;

endpackage : pipe_pkg

`default_nettype wire

// File: dm_bus_if.sv
/*
 * Four-phase req/ack data memory bus.
 * The load/store unit uses the master side, the data memory the slave side.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

interface dm_bus_if;

    logic                   req;
    logic                   ack;
    logic                   we;     // high for a store
    logic [`PIPE_XLEN-1:0]  addr;   // byte address
    logic [`PIPE_XLEN-1:0]  wdata;
    logic [`PIPE_XLEN-1:0]  rdata;  // valid while ack is high on a read

    modport master (output req, we, addr, wdata, input ack, rdata);
    modport slave  (input req, we, addr, wdata, output ack, rdata);

endinterface : dm_bus_if

`default_nettype wire

// File: hazard_unit.sv
/*
 * Hazard unit of the pipeline.
 * Picks execute operand bypasses, stalls on load-use and freezes the pipe
 * while a data memory transfer is still open.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module hazard_unit
(
    input  logic [`PIPE_RA_W-1:0]  wa3_exe,
    input  logic [`PIPE_RA_W-1:0]  wa3_mem,
    input  logic [`PIPE_RA_W-1:0]  wa3_wb,
    input  logic [`PIPE_RA_W-1:0]  ra1_id,
    input  logic [`PIPE_RA_W-1:0]  ra2_id,
    input  logic [`PIPE_RA_W-1:0]  ra1_exe,
    input  logic [`PIPE_RA_W-1:0]  ra2_exe,
    input  logic                   we_rf_exe,
    input  logic                   we_rf_mem,
    input  logic                   we_rf_wb,
    input  logic                   load_exe,
    input  logic                   req_ack_dm,  // memory stage done
    output pipe_pkg::bp_sel_e      rd1_bypass,
    output pipe_pkg::bp_sel_e      rd2_bypass,
    output logic                   stall_if,
    output logic                   stall_id,
    output logic                   stall_exe,
    output logic                   stall_mem,
    output logic                   stall_wb,
    output logic                   flush_exe
);

    logic lw_stall;
    logic mem_wait;

    // youngest writer wins, x0 never forwarded
    function automatic pipe_pkg::bp_sel_e bp_pick
    (
        input logic [`PIPE_RA_W-1:0] ra,
        input logic [`PIPE_RA_W-1:0] wa_mem,
        input logic                  we_mem,
        input logic [`PIPE_RA_W-1:0] wa_wb,
        input logic                  we_wb
    );
        bp_pick = pipe_pkg::BP_NONE;
        if (ra == '0)
            bp_pick = pipe_pkg::BP_NONE;
        else if (we_mem && (wa_mem == ra))
            bp_pick = pipe_pkg::BP_MEM;
        else if (we_wb && (wa_wb == ra))
            bp_pick = pipe_pkg::BP_WB;
    endfunction

    assign rd1_bypass = bp_pick(ra1_exe, wa3_mem, we_rf_mem, wa3_wb, we_rf_wb);
    assign rd2_bypass = bp_pick(ra2_exe, wa3_mem, we_rf_mem, wa3_wb, we_rf_wb);

    // load in execute feeding an instruction in decode
    assign lw_stall = load_exe && we_rf_exe && (wa3_exe != '0) &&
                      ((ra1_id == wa3_exe) || (ra2_id == wa3_exe));
    assign mem_wait = !req_ack_dm;

    assign stall_if  = lw_stall || mem_wait;
    assign stall_id  = lw_stall || mem_wait;
    assign stall_exe = mem_wait;
    assign stall_mem = mem_wait;
    assign stall_wb  = mem_wait;
    assign flush_exe = lw_stall;   // bubble into execute

endmodule : hazard_unit

`default_nettype wire

// File: reg_file.sv
/*
 * 32 x XLEN register file, two read ports for decode and one write port.
 * Reads are combinational with write-through, plus a debug read port.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module reg_file
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`PIPE_RA_W-1:0]  ra1,
    input  logic [`PIPE_RA_W-1:0]  ra2,
    input  logic [`PIPE_RA_W-1:0]  wa3,
    input  logic [`PIPE_RA_W-1:0]  dbg_ra,
    input  logic                   we3,
    input  logic [`PIPE_XLEN-1:0]  wd3,
    output logic [`PIPE_XLEN-1:0]  rd1,
    output logic [`PIPE_XLEN-1:0]  rd2,
    output logic [`PIPE_XLEN-1:0]  dbg_rd
);

    logic [`PIPE_XLEN-1:0] rf_q [2**`PIPE_RA_W];

    // x0 is hardwired, same-cycle write is passed through
    function automatic logic [`PIPE_XLEN-1:0] rd_port(input logic [`PIPE_RA_W-1:0] ra);
        if (ra == '0)
            rd_port = '0;
        else if (we3 && (wa3 == ra))
            rd_port = wd3;
        else
            rd_port = rf_q[ra];
    endfunction

    always_comb
    begin
        rd1    = rd_port(ra1);
        rd2    = rd_port(ra2);
        dbg_rd = rd_port(dbg_ra);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 2**`PIPE_RA_W; i++)
                rf_q[i] <= '0;
        end
        else if (we3 && (wa3 != '0))
            rf_q[wa3] <= wd3;
    end

endmodule : reg_file

`default_nettype wire

// File: lsu.sv
/*
 * Memory stage load/store unit.
 * Runs one four-phase transfer per LW or SW and reports completion on mem_done.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module lsu
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  pipe_pkg::op_e          op_mem,
    input  logic [`PIPE_XLEN-1:0]  addr,
    input  logic [`PIPE_XLEN-1:0]  wdata,
    output logic [`PIPE_XLEN-1:0]  rdata,
    output logic                   mem_done,
    dm_bus_if.master               bus
);

    pipe_pkg::lsu_state_e   state;
    pipe_pkg::lsu_state_e   state_next;
    logic                   is_mem;
    logic                   ack_seen;

    assign is_mem   = (op_mem == pipe_pkg::OP_LW) || (op_mem == pipe_pkg::OP_SW);
    assign ack_seen = (state == pipe_pkg::LSU_REQ) && bus.ack;

    // ==========================================================================
    // handshake FSM
    // ==========================================================================
    always_comb
    begin
        state_next = state;
        case (state)
            pipe_pkg::LSU_IDLE    : if (is_mem) state_next = pipe_pkg::LSU_REQ;
            pipe_pkg::LSU_REQ     : if (bus.ack) state_next = pipe_pkg::LSU_RELEASE;
            pipe_pkg::LSU_RELEASE : if (!bus.ack) state_next = pipe_pkg::LSU_IDLE;
            default               : state_next = pipe_pkg::LSU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= pipe_pkg::LSU_IDLE;
        else
            state <= state_next;
    end

    assign bus.req   = (state == pipe_pkg::LSU_REQ);
    assign bus.we    = (op_mem == pipe_pkg::OP_SW);
    assign bus.addr  = addr;
    assign bus.wdata = wdata;

    assign rdata    = bus.rdata;
    assign mem_done = !is_mem || ack_seen;   // stage advances once per op

endmodule : lsu

`default_nettype wire

// File: data_mem.sv
/*
 * Word-addressed data memory on the slave side of the four-phase bus.
 * Acknowledges after a fixed wait and releases ack once req has dropped.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module data_mem
(
    input  logic      clk,
    input  logic      arst_n,
    dm_bus_if.slave   bus
);

    localparam int unsigned AW = $clog2(`PIPE_DM_WORDS);
    localparam int unsigned CW = $clog2(`PIPE_DM_WAIT + 1);

    logic [`PIPE_XLEN-1:0]  mem [`PIPE_DM_WORDS];
    logic [AW-1:0]          word_idx;
    logic [CW-1:0]          wait_cnt;
    logic                   ack_rise;

    assign word_idx = bus.addr[AW+1:2];   // drop byte offset
    assign ack_rise = bus.req && !bus.ack && (wait_cnt == CW'(`PIPE_DM_WAIT - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus.ack  <= 1'b0;
            wait_cnt <= '0;
        end
        else if (ack_rise)
        begin
            bus.ack  <= 1'b1;
            wait_cnt <= '0;
        end
        else if (bus.req && !bus.ack)
            wait_cnt <= wait_cnt + 1'b1;
        else if (!bus.req && bus.ack)
            bus.ack <= 1'b0;       // release phase
    end

    // access happens with the rising ack
    always_ff @(posedge clk)
    begin
        if (ack_rise && bus.we)
            mem[word_idx] <= bus.wdata;
        if (ack_rise && !bus.we)
            bus.rdata <= mem[word_idx];
    end

endmodule : data_mem

`default_nettype wire

// File: pipe_core.sv
/*
 * Five-stage in-order core running ADD, ADDI, LW and SW.
 * Instructions come in on a combinational fetch port, data goes through the
 * load/store unit to the handshake data memory.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module pipe_core
(
    input  logic                   clk,
    input  logic                   arst_n,
    output logic [`PIPE_XLEN-1:0]  instr_addr,
    input  logic [`PIPE_XLEN-1:0]  instr,
    input  logic [`PIPE_RA_W-1:0]  dbg_ra,
    output logic [`PIPE_XLEN-1:0]  dbg_rd
);

    pipe_pkg::bp_sel_e      rd1_bypass;
    pipe_pkg::bp_sel_e      rd2_bypass;
    logic                   stall_if, stall_id, stall_exe, stall_mem, stall_wb;
    logic                   flush_exe;
    // fetch and decode
    logic [`PIPE_XLEN-1:0]  pc;
    logic [`PIPE_XLEN-1:0]  instr_id;
    pipe_pkg::op_e          op_id;
    logic                   we_id;
    logic [`PIPE_RA_W-1:0]  ra1_id, ra2_id, wa3_id;
    logic [`PIPE_XLEN-1:0]  imm_id, rd1_id, rd2_id;
    // execute
    pipe_pkg::op_e          op_exe;
    logic                   we_exe;
    logic [`PIPE_RA_W-1:0]  ra1_exe, ra2_exe, wa3_exe;
    logic [`PIPE_XLEN-1:0]  imm_exe, rd1_exe, rd2_exe;
    logic [`PIPE_XLEN-1:0]  src_a, src_b, alu_exe;
    // memory and write-back
    pipe_pkg::op_e          op_mem;
    logic                   we_mem, we_wb, mem_done;
    logic [`PIPE_RA_W-1:0]  wa3_mem, wa3_wb;
    logic [`PIPE_XLEN-1:0]  alu_mem, sd_mem, lsu_rdata, wd_mem, wd_wb;

    dm_bus_if dm_bus ();

    // ==========================================================================
    // fetch
    // ==========================================================================
    assign instr_addr = pc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc       <= '0;
            instr_id <= '0;   // decodes as nop
        end
        else
        begin
            if (!stall_if)
                pc <= pc + 'd4;
            if (!stall_id)
                instr_id <= instr;
        end
    end

    // ==========================================================================
    // decode
    // ==========================================================================
    always_comb
    begin
        op_id  = pipe_pkg::OP_NOP;
        imm_id = {{(`PIPE_XLEN-12){instr_id[31]}}, instr_id[31:20]};   // I-type
        case (instr_id[6:0])
            7'b0110011 :
                if (instr_id[14:12] == 3'b000 && instr_id[31:25] == 7'b0)
                    op_id = pipe_pkg::OP_ADD;
            7'b0010011 : if (instr_id[14:12] == 3'b000) op_id = pipe_pkg::OP_ADDI;
            7'b0000011 : if (instr_id[14:12] == 3'b010) op_id = pipe_pkg::OP_LW;
            7'b0100011 :
                if (instr_id[14:12] == 3'b010)
                begin
                    op_id  = pipe_pkg::OP_SW;
                    imm_id = {{(`PIPE_XLEN-12){instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
                end
            default    : ;   // anything else is a nop
        endcase
    end

    // unused fields zeroed so they never raise hazards
    assign we_id  = op_id inside {pipe_pkg::OP_ADD, pipe_pkg::OP_ADDI, pipe_pkg::OP_LW};
    assign ra1_id = (op_id == pipe_pkg::OP_NOP) ? '0 : instr_id[19:15];
    assign ra2_id = (op_id inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SW}) ? instr_id[24:20] : '0;
    assign wa3_id = we_id ? instr_id[11:7] : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_exe  <= pipe_pkg::OP_NOP;
            we_exe  <= 1'b0;
            wa3_exe <= '0;
            ra1_exe <= '0;
            ra2_exe <= '0;
        end
        else if (!stall_exe)
        begin
            op_exe  <= flush_exe ? pipe_pkg::OP_NOP : op_id;
            we_exe  <= flush_exe ? 1'b0 : we_id;
            wa3_exe <= flush_exe ? '0 : wa3_id;
            ra1_exe <= flush_exe ? '0 : ra1_id;
            ra2_exe <= flush_exe ? '0 : ra2_id;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_exe)
        begin
            imm_exe <= imm_id;
            rd1_exe <= rd1_id;
            rd2_exe <= rd2_id;
        end
    end

    // ==========================================================================
    // execute
    // ==========================================================================
    function automatic logic [`PIPE_XLEN-1:0] bp_mux
    (
        input pipe_pkg::bp_sel_e     sel,
        input logic [`PIPE_XLEN-1:0] rf_val,
        input logic [`PIPE_XLEN-1:0] mem_val,
        input logic [`PIPE_XLEN-1:0] wb_val
    );
        case (sel)
            pipe_pkg::BP_MEM : bp_mux = mem_val;
            pipe_pkg::BP_WB  : bp_mux = wb_val;
            default          : bp_mux = rf_val;
        endcase
    endfunction

    assign src_a   = bp_mux(rd1_bypass, rd1_exe, alu_mem, wd_wb);
    assign src_b   = bp_mux(rd2_bypass, rd2_exe, alu_mem, wd_wb);   // also store data
    assign alu_exe = src_a + ((op_exe == pipe_pkg::OP_ADD) ? src_b : imm_exe);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_mem  <= pipe_pkg::OP_NOP;
            we_mem  <= 1'b0;
            wa3_mem <= '0;
        end
        else if (!stall_mem)
        begin
            op_mem  <= op_exe;
            we_mem  <= we_exe;
            wa3_mem <= wa3_exe;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_mem)
        begin
            alu_mem <= alu_exe;
            sd_mem  <= src_b;
        end
    end

    // ==========================================================================
    // memory and write-back
    // ==========================================================================
    assign wd_mem = (op_mem == pipe_pkg::OP_LW) ? lsu_rdata : alu_mem;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            we_wb  <= 1'b0;
            wa3_wb <= '0;
        end
        else if (!stall_wb)
        begin
            we_wb  <= we_mem;
            wa3_wb <= wa3_mem;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_wb)
            wd_wb <= wd_mem;
    end

    hazard_unit u_hazard
    (
        .wa3_exe    (wa3_exe),
        .wa3_mem    (wa3_mem),
        .wa3_wb     (wa3_wb),
        .ra1_id     (ra1_id),
        .ra2_id     (ra2_id),
        .ra1_exe    (ra1_exe),
        .ra2_exe    (ra2_exe),
        .we_rf_exe  (we_exe),
        .we_rf_mem  (we_mem),
        .we_rf_wb   (we_wb),
        .load_exe   (op_exe == pipe_pkg::OP_LW),
        .req_ack_dm (mem_done),
        .rd1_bypass (rd1_bypass),
        .rd2_bypass (rd2_bypass),
        .stall_if   (stall_if),
        .stall_id   (stall_id),
        .stall_exe  (stall_exe),
        .stall_mem  (stall_mem),
        .stall_wb   (stall_wb),
        .flush_exe  (flush_exe)
    );

    reg_file u_rf
    (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (ra1_id),
        .ra2    (ra2_id),
        .wa3    (wa3_wb),
        .dbg_ra (dbg_ra),
        .we3    (we_wb),
        .wd3    (wd_wb),
        .rd1    (rd1_id),
        .rd2    (rd2_id),
        .dbg_rd (dbg_rd)
    );

    lsu u_lsu
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_mem   (op_mem),
        .addr     (alu_mem),
        .wdata    (sd_mem),
        .rdata    (lsu_rdata),
        .mem_done (mem_done),
        .bus      (dm_bus)
    );

    data_mem u_dmem
    (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (dm_bus)
    );

endmodule : pipe_core

`default_nettype wire

// File: tb_pipe_core.sv
/*
 * Directed testbench for the five-stage core.
 * Each test loads a small program into the instruction array, resets the core,
 * lets it drain and reads registers back through the debug port.
 */

`timescale 1ns/1ps
`default_nettype none
`include "pipe_defs.svh"

module tb_pipe_core;

    localparam int ROM_AW    = 6;
    localparam int ROM_WORDS = 2**ROM_AW;
    localparam int DM_AW     = $clog2(`PIPE_DM_WORDS);
    localparam int DRAIN     = 8;                       // fetches past the program end
    localparam int N_TESTS   = 5;
    localparam int PROG_SUM  = 8 + 12 + 6 + 8 + 3;      // all program lengths
    localparam int MEM_OPS   = 6;
    localparam int TEST_OVH  = 3 + 2 + DRAIN + 32;      // reset, drain and register reads
    localparam int CYCLE_LIMIT =
        2 * (PROG_SUM + N_TESTS * TEST_OVH + MEM_OPS * (`PIPE_DM_WAIT + 3));
    localparam logic [31:0] NOP = 32'h0000_0013;        // addi x0, x0, 0

    logic                   clk;
    logic                   arst_n;
    logic [`PIPE_XLEN-1:0]  instr_addr;
    logic [`PIPE_XLEN-1:0]  instr;
    logic [`PIPE_RA_W-1:0]  dbg_ra;
    logic [`PIPE_XLEN-1:0]  dbg_rd;

    logic [31:0]            rom [ROM_WORDS];
    logic [`PIPE_XLEN-1:0]  model_rf [2**`PIPE_RA_W];   // expected architectural state
    logic [`PIPE_XLEN-1:0]  model_dm [`PIPE_DM_WORDS];
    int                     prog_len;
    int                     cycles = 0;
    int                     seed;

    pipe_core UUT
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .dbg_ra     (dbg_ra),
        .dbg_rd     (dbg_rd)
    );

    // combinational fetch port
    assign instr = (instr_addr < ROM_WORDS * 4) ? rom[instr_addr[ROM_AW+1:2]] : NOP;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            stop_run($sformatf("timeout after %0d cycles, program never drained", cycles));
    end

    // ========================================================================
    // reporting and compare tasks
    // ========================================================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_reg(input string test, input logic [`PIPE_XLEN-1:0] exp,
                             input logic [`PIPE_XLEN-1:0] got);
        if (got !== exp)
            stop_run($sformatf("ERR %s exp %h got %h", test, exp, got));
    endtask

    task automatic check_addr(input string test, input logic [`PIPE_XLEN-1:0] exp,
                              input logic [`PIPE_XLEN-1:0] got);
        if (got !== exp)
            stop_run($sformatf("ERR %s instr_addr exp %h got %h", test, exp, got));
    endtask

    // ========================================================================
    // program builder with ISA model
    // ========================================================================
    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic new_program();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = NOP;
        for (int r = 0; r < 2**`PIPE_RA_W; r++)
            model_rf[r] = '0;   // core regs clear on reset
        prog_len = 0;
    endtask

    task automatic put_instr(input logic [31:0] word);
        if (prog_len >= ROM_WORDS)
            stop_run("program does not fit in the instruction array");
        else
        begin
            rom[prog_len] = word;
            prog_len++;
        end
    endtask

    task automatic emit_addi(input int rd, input int rs1, input logic [11:0] imm);
        put_instr({imm, `PIPE_RA_W'(rs1), 3'b000, `PIPE_RA_W'(rd), 7'b0010011});
        if (rd != 0)
            model_rf[rd] = model_rf[rs1] + sext12(imm);
    endtask

    task automatic emit_add(input int rd, input int rs1, input int rs2);
        put_instr({7'b0, `PIPE_RA_W'(rs2), `PIPE_RA_W'(rs1), 3'b000, `PIPE_RA_W'(rd),
                   7'b0110011});
        if (rd != 0)
            model_rf[rd] = model_rf[rs1] + model_rf[rs2];
    endtask

    task automatic emit_lw(input int rd, input int rs1, input logic [11:0] imm);
        logic [`PIPE_XLEN-1:0] ea;
        ea = model_rf[rs1] + sext12(imm);
        put_instr({imm, `PIPE_RA_W'(rs1), 3'b010, `PIPE_RA_W'(rd), 7'b0000011});
        if (rd != 0)
            model_rf[rd] = model_dm[ea[DM_AW+1:2]];
    endtask

    task automatic emit_sw(input int rs2, input int rs1, input logic [11:0] imm);
        logic [`PIPE_XLEN-1:0] ea;
        ea = model_rf[rs1] + sext12(imm);
        put_instr({imm[11:5], `PIPE_RA_W'(rs2), `PIPE_RA_W'(rs1), 3'b010, imm[4:0],
                   7'b0100011});
        model_dm[ea[DM_AW+1:2]] = model_rf[rs2];
    endtask

    // ========================================================================
    // run control
    // ========================================================================
    task automatic apply_reset(input string test);
        @(posedge clk);
        #1 arst_n = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_addr(test, '0, instr_addr);   // pc held during reset
            @(posedge clk);
        end
        #1 arst_n = 1'b1;
        @(negedge clk);
        check_addr(test, '0, instr_addr);
    endtask

    task automatic run_program(input string test);
        apply_reset(test);
        while (instr_addr < (prog_len + DRAIN) * 4)
            @(negedge clk);
    endtask

    task automatic verify_reg(input string test, input int idx);
        @(posedge clk);
        #1 dbg_ra = `PIPE_RA_W'(idx);
        @(negedge clk);
        check_reg($sformatf("%s x%0d", test, idx), model_rf[idx], dbg_rd);
    endtask

    // ========================================================================
    // tests
    // ========================================================================
    task automatic test_reset_state();
        new_program();
        repeat (8) put_instr(NOP);
        run_program("reset_state");
        for (int r = 0; r < 2**`PIPE_RA_W; r++)
            verify_reg("reset_state", r);
    endtask

    task automatic test_alu_forward();
        logic [11:0] imm;
        new_program();
        imm = 12'($random(seed));
        emit_addi(1, 0, imm);
        imm = 12'($random(seed));
        emit_addi(2, 1, imm);
        for (int k = 3; k <= 12; k++)
        begin
            imm = 12'($random(seed));
            if (k % 3 == 0)
                emit_addi(k, k - 1, imm);
            else if (k % 2 == 0)
                emit_add(k, k - 1, k - 2);   // rs1 from memory stage
            else
                emit_add(k, k - 2, k - 1);   // rs1 from write-back
        end
        run_program("alu_forward");
        for (int r = 1; r <= 12; r++)
            verify_reg("alu_forward", r);
    endtask

    task automatic test_load_use();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        new_program();
        imm_a = 12'($random(seed));
        imm_b = 12'($random(seed));
        emit_addi(1, 0, imm_a);
        emit_addi(2, 0, 12'h040);   // data base address
        emit_addi(3, 0, imm_b);
        emit_sw(1, 2, 12'h004);
        emit_lw(4, 2, 12'h004);
        emit_add(3, 4, 3);          // uses the load at once and rewrites x3
        run_program("load_use");
        verify_reg("load_use", 3);
        verify_reg("load_use", 4);
    endtask

    task automatic test_mem_backpressure();
        new_program();
        emit_addi(6, 0, 12'($random(seed)));
        emit_addi(7, 0, 12'($random(seed)));
        emit_addi(8, 0, 12'h100);
        emit_sw(6, 8, 12'h000);
        emit_sw(7, 8, 12'h008);     // waits for release of the first store
        emit_lw(9, 8, 12'h000);
        emit_lw(10, 8, 12'h008);
        emit_add(11, 9, 10);
        run_program("mem_backpressure");
        for (int r = 9; r <= 11; r++)
            verify_reg("mem_backpressure", r);
    endtask

    task automatic test_zero_reg();
        new_program();
        emit_addi(0, 0, 12'h5a5);   // dropped write
        emit_addi(13, 0, 12'h007);  // x0 still in flight in memory stage
        emit_add(14, 0, 13);
        run_program("zero_reg");
        verify_reg("zero_reg", 0);
        verify_reg("zero_reg", 13);
        verify_reg("zero_reg", 14);
    endtask

    initial
    begin
        arst_n   = 1'b0;
        dbg_ra   = '0;
        seed     = 32'h601f_f0d7;
        prog_len = 0;
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = NOP;

        test_reset_state();
        test_alu_forward();
        test_load_use();
        test_mem_backpressure();
        test_zero_reg();

        $display("** PASS **");
        $finish;
    end

endmodule : tb_pipe_core

`default_nettype wire

// File: sources.f
+incdir+.
pipe_pkg.sv
dm_bus_if.sv
hazard_unit.sv
reg_file.sv
lsu.sv
data_mem.sv
pipe_core.sv
tb_pipe_core.sv
